//--- hps_bus_pkg.sv
package hps_bus_pkg;

	// ========================================================================
	// Bus word types
	// ========================================================================

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  strb_t;
	typedef logic [1:0]  resp_t;

	// Shared by the write-address and read-address channels
	typedef struct packed {
		addr_t       addr;
		logic [2:0]  prot;
	} addr_chan_t;

	typedef struct packed {
		data_t       data;
		strb_t       strb;
	} wdata_chan_t;

	typedef struct packed {
		data_t       data;
		resp_t       resp;
	} rdata_chan_t;

	// One single-beat transaction as seen by the bus engine
	typedef struct packed {
		logic        write;
		addr_t       addr;
		data_t       wdata;
	} bus_req_t;

	// ========================================================================
	// UART register map
	// ========================================================================

	localparam addr_t       uart_thr_offset   = 32'h0000_0000;
	localparam addr_t       uart_lsr_offset   = 32'h0000_0014;
	localparam int unsigned uart_lsr_thre_bit = 5;
	localparam addr_t       uart_default_base = 32'hFFC0_2000;

endpackage

//--- adc_report_pkg.sv
package adc_report_pkg;

	typedef logic [11:0] sample_t;
	typedef logic [7:0]  char_t;
	typedef logic [5:0]  adc_config_t;

	// Single-ended, channel 0, unipolar, no sleep
	localparam adc_config_t adc_config_ch0 = 6'b100010;

	localparam int unsigned adc_sample_bits = 12;

	// Length of "ch0=0x"
	localparam int unsigned report_prefix_len = 6;
	localparam int unsigned report_hex_digits = 4;

	// Report line sequencer states
	typedef enum logic [2:0] {
		seq_delay,
		seq_prefix,
		seq_wait_sample,
		seq_hex,
		seq_cr,
		seq_lf
	} seq_state_t;

endpackage

//--- ltc2308_reader.sv
`timescale 1ns/1ps

module ltc2308_reader #(
	parameter int unsigned conv_wait_cycles = 80,
	parameter int unsigned sck_half_cycles  = 2
) (
	input  logic                    pll0_clock0,
	input  logic                    master_reset_n,
	output logic                    adc_convst,
	output logic                    adc_sck,
	output logic                    adc_sdi,
	input  logic                    adc_sdo,
	output adc_report_pkg::sample_t sample,
	output logic                    sample_valid
);

	localparam int cnt_w = $clog2(conv_wait_cycles + sck_half_cycles + 1);
	localparam logic [3:0] last_bit = 4'(adc_report_pkg::adc_sample_bits - 1);

	typedef enum logic [1:0] {
		ph_idle,
		ph_conv,
		ph_low,
		ph_high
	} phase_t;

	phase_t                      phase;
	logic [cnt_w-1:0]            cycle_cnt;
	logic [3:0]                  bit_cnt;
	adc_report_pkg::adc_config_t cfg_sr;
	adc_report_pkg::sample_t     shift_sr;

	// ========================================================================
	// Frame phases: conversion, then 12 SCK periods
	// ========================================================================

	always_ff @(posedge pll0_clock0 or negedge master_reset_n) begin
		if (!master_reset_n) begin
			phase      <= ph_idle;
			cycle_cnt  <= '0;
			bit_cnt    <= '0;
			cfg_sr     <= '0;
			adc_convst <= 1'b0;
			adc_sck    <= 1'b0;
			adc_sdi    <= 1'b0;
		end else begin
			unique case (phase)
				ph_idle: begin
					adc_convst <= 1'b1;
					phase      <= ph_conv;
				end
				ph_conv: begin
					if (cycle_cnt == cnt_w'(conv_wait_cycles - 1)) begin
						cycle_cnt  <= '0;
						bit_cnt    <= '0;
						adc_convst <= 1'b0;
						// First config bit goes out while SCK is still low
						adc_sdi    <= adc_report_pkg::adc_config_ch0[5];
						cfg_sr     <= adc_report_pkg::adc_config_ch0 << 1;
						phase      <= ph_low;
					end else begin
						cycle_cnt <= cycle_cnt + 1'b1;
					end
				end
				ph_low: begin
					if (cycle_cnt == cnt_w'(sck_half_cycles - 1)) begin
						cycle_cnt <= '0;
						adc_sck   <= 1'b1;
						phase     <= ph_high;
					end else begin
						cycle_cnt <= cycle_cnt + 1'b1;
					end
				end
				ph_high: begin
					if (cycle_cnt == cnt_w'(sck_half_cycles - 1)) begin
						cycle_cnt <= '0;
						adc_sck   <= 1'b0;
						if (bit_cnt == last_bit) begin
							adc_convst <= 1'b1;
							phase      <= ph_conv;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
							// Zeros follow once the six config bits are out
							adc_sdi <= cfg_sr[5];
							cfg_sr  <= cfg_sr << 1;
							phase   <= ph_low;
						end
					end else begin
						cycle_cnt <= cycle_cnt + 1'b1;
					end
				end
				default: phase <= ph_idle;
			endcase
		end
	end

	// SDO captured together with the rising SCK edge, MSB first
	always_ff @(posedge pll0_clock0) begin
		if (phase == ph_low && cycle_cnt == cnt_w'(sck_half_cycles - 1)) begin
			shift_sr <= {shift_sr[10:0], adc_sdo};
		end
		if (phase == ph_high && cycle_cnt == '0 && bit_cnt == last_bit) begin
			sample <= shift_sr;
		end
	end

	// One cycle after the twelfth rising edge
	always_ff @(posedge pll0_clock0 or negedge master_reset_n) begin
		if (!master_reset_n) begin
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= (phase == ph_high) && (cycle_cnt == '0) && (bit_cnt == last_bit);
		end
	end

endmodule

//--- report_sequencer.sv
`timescale 1ns/1ps

module report_sequencer #(
	parameter int unsigned report_delay_cycles = 2**25
) (
	input  logic                    pll0_clock0,
	input  logic                    master_reset_n,
	input  adc_report_pkg::sample_t sample,
	input  logic                    sample_valid,
	output adc_report_pkg::char_t   char,
	output logic                    char_valid,
	input  logic                    char_ready
);

	localparam int delay_w  = $clog2(report_delay_cycles + 1);
	localparam int hex_bits = 4 * adc_report_pkg::report_hex_digits;
	localparam int prefix_w = 8 * adc_report_pkg::report_prefix_len;
	localparam logic [prefix_w-1:0] prefix_text = "ch0=0x";

	adc_report_pkg::seq_state_t state;
	logic [delay_w-1:0]         delay_cnt;
	logic [2:0]                 char_cnt;
	adc_report_pkg::sample_t    sample_q;
	logic [hex_bits-1:0]        hex_word;
	logic                       char_taken;

	function automatic adc_report_pkg::char_t hex_to_ascii(input logic [3:0] nib);
		adc_report_pkg::char_t c;
		if (nib < 4'd10) begin
			c = 8'h30 + {4'h0, nib};
		end else begin
			c = 8'h37 + {4'h0, nib};
		end
		return c;
	endfunction

	assign hex_word   = hex_bits'(sample_q);
	assign char_taken = char_valid && char_ready;

	// ========================================================================
	// Line state machine
	// ========================================================================

	always_ff @(posedge pll0_clock0 or negedge master_reset_n) begin
		if (!master_reset_n) begin
			state     <= adc_report_pkg::seq_delay;
			delay_cnt <= '0;
			char_cnt  <= '0;
		end else begin
			unique case (state)
				adc_report_pkg::seq_delay: begin
					if (delay_cnt == delay_w'(report_delay_cycles - 1)) begin
						delay_cnt <= '0;
						char_cnt  <= '0;
						state     <= adc_report_pkg::seq_prefix;
					end else begin
						delay_cnt <= delay_cnt + 1'b1;
					end
				end
				adc_report_pkg::seq_prefix: begin
					if (char_taken) begin
						if (char_cnt == 3'(adc_report_pkg::report_prefix_len - 1)) begin
							char_cnt <= '0;
							state    <= adc_report_pkg::seq_wait_sample;
						end else begin
							char_cnt <= char_cnt + 1'b1;
						end
					end
				end
				// Samples arriving earlier are dropped
				adc_report_pkg::seq_wait_sample: begin
					if (sample_valid) begin
						state <= adc_report_pkg::seq_hex;
					end
				end
				adc_report_pkg::seq_hex: begin
					if (char_taken) begin
						if (char_cnt == 3'(adc_report_pkg::report_hex_digits - 1)) begin
							char_cnt <= '0;
							state    <= adc_report_pkg::seq_cr;
						end else begin
							char_cnt <= char_cnt + 1'b1;
						end
					end
				end
				adc_report_pkg::seq_cr: begin
					if (char_taken) begin
						state <= adc_report_pkg::seq_lf;
					end
				end
				adc_report_pkg::seq_lf: begin
					if (char_taken) begin
						state <= adc_report_pkg::seq_delay;
					end
				end
				default: state <= adc_report_pkg::seq_delay;
			endcase
		end
	end

	always_ff @(posedge pll0_clock0) begin
		if (state == adc_report_pkg::seq_wait_sample && sample_valid) begin
			sample_q <= sample;
		end
	end

	// Character mux, most significant digit first
	always_comb begin
		char       = '0;
		char_valid = 1'b0;
		unique case (state)
			adc_report_pkg::seq_prefix: begin
				char_valid = 1'b1;
				char = prefix_text[8 * (adc_report_pkg::report_prefix_len - 1 - char_cnt) +: 8];
			end
			adc_report_pkg::seq_hex: begin
				char_valid = 1'b1;
				char = hex_to_ascii(
					hex_word[4 * (adc_report_pkg::report_hex_digits - 1 - char_cnt) +: 4]);
			end
			adc_report_pkg::seq_cr: begin
				char_valid = 1'b1;
				char       = 8'h0D;
			end
			adc_report_pkg::seq_lf: begin
				char_valid = 1'b1;
				char       = 8'h0A;
			end
			default: begin
				char_valid = 1'b0;
			end
		endcase
	end

endmodule

//--- uart_tx_writer.sv
`timescale 1ns/1ps

module uart_tx_writer #(
	parameter hps_bus_pkg::addr_t uart_base_addr = hps_bus_pkg::uart_default_base
) (
	input  logic                   pll0_clock0,
	input  logic                   master_reset_n,
	input  adc_report_pkg::char_t  char,
	input  logic                   char_valid,
	output logic                   char_ready,
	output hps_bus_pkg::bus_req_t  req,
	output logic                   req_valid,
	input  logic                   req_ready,
	input  hps_bus_pkg::data_t     rsp_data,
	input  logic                   rsp_valid
);

	typedef enum logic [2:0] {
		wr_idle,
		wr_lsr_req,
		wr_lsr_wait,
		wr_thr_req,
		wr_thr_wait
	} wr_state_t;

	wr_state_t             state;
	adc_report_pkg::char_t char_q;

	assign char_ready = (state == wr_idle);

	always_ff @(posedge pll0_clock0 or negedge master_reset_n) begin
		if (!master_reset_n) begin
			state <= wr_idle;
		end else begin
			unique case (state)
				wr_idle: begin
					if (char_valid) begin
						state <= wr_lsr_req;
					end
				end
				wr_lsr_req: begin
					if (req_ready) begin
						state <= wr_lsr_wait;
					end
				end
				// Poll again until the holding register is empty
				wr_lsr_wait: begin
					if (rsp_valid) begin
						if (rsp_data[hps_bus_pkg::uart_lsr_thre_bit]) begin
							state <= wr_thr_req;
						end else begin
							state <= wr_lsr_req;
						end
					end
				end
				wr_thr_req: begin
					if (req_ready) begin
						state <= wr_thr_wait;
					end
				end
				wr_thr_wait: begin
					if (rsp_valid) begin
						state <= wr_idle;
					end
				end
				default: state <= wr_idle;
			endcase
		end
	end

	always_ff @(posedge pll0_clock0) begin
		if (char_valid && char_ready) begin
			char_q <= char;
		end
	end

	always_comb begin
		req       = '0;
		req_valid = 1'b0;
		if (state == wr_lsr_req) begin
			req_valid = 1'b1;
			req.write = 1'b0;
			req.addr  = uart_base_addr + hps_bus_pkg::uart_lsr_offset;
		end else if (state == wr_thr_req) begin
			req_valid = 1'b1;
			req.write = 1'b1;
			req.addr  = uart_base_addr + hps_bus_pkg::uart_thr_offset;
			req.wdata = hps_bus_pkg::data_t'(char_q);
		end
	end

endmodule

//--- axi_single_master.sv
`timescale 1ns/1ps

module axi_single_master (
	input  logic                     pll0_clock0,
	input  logic                     master_reset_n,
	input  hps_bus_pkg::bus_req_t    req,
	input  logic                     req_valid,
	output logic                     req_ready,
	output hps_bus_pkg::data_t       rsp_data,
	output logic                     rsp_valid,
	output hps_bus_pkg::addr_chan_t  aw,
	output logic                     aw_valid,
	input  logic                     aw_ready,
	output hps_bus_pkg::wdata_chan_t w,
	output logic                     w_valid,
	input  logic                     w_ready,
	input  hps_bus_pkg::resp_t       b_resp,
	input  logic                     b_valid,
	output logic                     b_ready,
	output hps_bus_pkg::addr_chan_t  ar,
	output logic                     ar_valid,
	input  logic                     ar_ready,
	input  hps_bus_pkg::rdata_chan_t r,
	input  logic                     r_valid,
	output logic                     r_ready
);

	typedef enum logic [1:0] {
		m_idle,
		m_write,
		m_read,
		m_done
	} m_state_t;

	m_state_t                 state;
	hps_bus_pkg::addr_chan_t  addr_q;
	hps_bus_pkg::wdata_chan_t wdata_q;

	assign req_ready = (state == m_idle);
	assign rsp_valid = (state == m_done);
	assign b_ready   = (state == m_write);
	assign r_ready   = (state == m_read);
	assign aw        = addr_q;
	assign ar        = addr_q;
	assign w         = wdata_q;

	// ========================================================================
	// Transaction control
	// ========================================================================

	always_ff @(posedge pll0_clock0 or negedge master_reset_n) begin
		if (!master_reset_n) begin
			state    <= m_idle;
			aw_valid <= 1'b0;
			w_valid  <= 1'b0;
			ar_valid <= 1'b0;
		end else begin
			unique case (state)
				m_idle: begin
					if (req_valid) begin
						if (req.write) begin
							aw_valid <= 1'b1;
							w_valid  <= 1'b1;
							state    <= m_write;
						end else begin
							ar_valid <= 1'b1;
							state    <= m_read;
						end
					end
				end
				// Address and data may be accepted in either order
				m_write: begin
					if (aw_valid && aw_ready) begin
						aw_valid <= 1'b0;
					end
					if (w_valid && w_ready) begin
						w_valid <= 1'b0;
					end
					if (b_valid) begin
						state <= m_done;
					end
				end
				m_read: begin
					if (ar_valid && ar_ready) begin
						ar_valid <= 1'b0;
					end
					if (r_valid) begin
						state <= m_done;
					end
				end
				m_done: begin
					state <= m_idle;
				end
				default: state <= m_idle;
			endcase
		end
	end

	always_ff @(posedge pll0_clock0) begin
		if (state == m_idle && req_valid) begin
			addr_q  <= '{addr: req.addr, prot: 3'b000};
			wdata_q <= '{data: req.wdata, strb: 4'b0001};
		end
		// Write completion returns the response code in the low bits
		if (state == m_write && b_valid) begin
			rsp_data <= hps_bus_pkg::data_t'(b_resp);
		end
		if (state == m_read && r_valid) begin
			rsp_data <= r.data;
		end
	end

endmodule

//--- adc_uart_report.sv
`timescale 1ns/1ps

module adc_uart_report #(
	parameter hps_bus_pkg::addr_t uart_base_addr      = hps_bus_pkg::uart_default_base,
	parameter int unsigned        report_delay_cycles = 2**25,
	parameter int unsigned        conv_wait_cycles    = 80,
	parameter int unsigned        sck_half_cycles     = 2
) (
	input  logic                     pll0_clock0,
	input  logic                     master_reset_n,
	output logic                     adc_convst,
	output logic                     adc_sck,
	output logic                     adc_sdi,
	input  logic                     adc_sdo,
	output hps_bus_pkg::addr_chan_t  aw,
	output logic                     aw_valid,
	input  logic                     aw_ready,
	output hps_bus_pkg::wdata_chan_t w,
	output logic                     w_valid,
	input  logic                     w_ready,
	input  hps_bus_pkg::resp_t       b_resp,
	input  logic                     b_valid,
	output logic                     b_ready,
	output hps_bus_pkg::addr_chan_t  ar,
	output logic                     ar_valid,
	input  logic                     ar_ready,
	input  hps_bus_pkg::rdata_chan_t r,
	input  logic                     r_valid,
	output logic                     r_ready
);

	adc_report_pkg::sample_t sample;
	logic                    sample_valid;
	adc_report_pkg::char_t   char;
	logic                    char_valid;
	logic                    char_ready;
	hps_bus_pkg::bus_req_t   req;
	logic                    req_valid;
	logic                    req_ready;
	hps_bus_pkg::data_t      rsp_data;
	logic                    rsp_valid;

	// ========================================================================
	// ADC readout and line composition
	// ========================================================================

	ltc2308_reader #(
		.conv_wait_cycles (conv_wait_cycles),
		.sck_half_cycles  (sck_half_cycles)
	) u_reader (
		.pll0_clock0    (pll0_clock0),
		.master_reset_n (master_reset_n),
		.adc_convst     (adc_convst),
		.adc_sck        (adc_sck),
		.adc_sdi        (adc_sdi),
		.adc_sdo        (adc_sdo),
		.sample         (sample),
		.sample_valid   (sample_valid)
	);

	report_sequencer #(
		.report_delay_cycles (report_delay_cycles)
	) u_sequencer (
		.pll0_clock0    (pll0_clock0),
		.master_reset_n (master_reset_n),
		.sample         (sample),
		.sample_valid   (sample_valid),
		.char           (char),
		.char_valid     (char_valid),
		.char_ready     (char_ready)
	);

	// ========================================================================
	// UART register access over the bus
	// ========================================================================

	uart_tx_writer #(
		.uart_base_addr (uart_base_addr)
	) u_writer (
		.pll0_clock0    (pll0_clock0),
		.master_reset_n (master_reset_n),
		.char           (char),
		.char_valid     (char_valid),
		.char_ready     (char_ready),
		.req            (req),
		.req_valid      (req_valid),
		.req_ready      (req_ready),
		.rsp_data       (rsp_data),
		.rsp_valid      (rsp_valid)
	);

	axi_single_master u_master (
		.pll0_clock0    (pll0_clock0),
		.master_reset_n (master_reset_n),
		.req            (req),
		.req_valid      (req_valid),
		.req_ready      (req_ready),
		.rsp_data       (rsp_data),
		.rsp_valid      (rsp_valid),
		.aw             (aw),
		.aw_valid       (aw_valid),
		.aw_ready       (aw_ready),
		.w              (w),
		.w_valid        (w_valid),
		.w_ready        (w_ready),
		.b_resp         (b_resp),
		.b_valid        (b_valid),
		.b_ready        (b_ready),
		.ar             (ar),
		.ar_valid       (ar_valid),
		.ar_ready       (ar_ready),
		.r              (r),
		.r_valid        (r_valid),
		.r_ready        (r_ready)
	);

endmodule

//--- adc_uart_report_sva.sv
`timescale 1ns/1ps

module axi_handshake_sva (
	input logic                     pll0_clock0,
	input logic                     master_reset_n,
	input hps_bus_pkg::addr_chan_t  aw,
	input logic                     aw_valid,
	input logic                     aw_ready,
	input hps_bus_pkg::wdata_chan_t w,
	input logic                     w_valid,
	input logic                     w_ready,
	input logic                     b_valid,
	input logic                     b_ready,
	input hps_bus_pkg::addr_chan_t  ar,
	input logic                     ar_valid,
	input logic                     ar_ready,
	input logic                     r_valid,
	input logic                     r_ready,
	input logic                     rsp_valid
);

	// Number of assertion failures so far
	int unsigned fail_count = 0;

	// ========================================================================
	// Request channels hold until accepted
	// ========================================================================

	aw_hold: assert property (@(posedge pll0_clock0) disable iff (!master_reset_n)
		aw_valid && !aw_ready |=> aw_valid && $stable(aw))
		else begin
			fail_count++;
			$error("aw_valid dropped or aw changed before aw_ready");
		end

	w_hold: assert property (@(posedge pll0_clock0) disable iff (!master_reset_n)
		w_valid && !w_ready |=> w_valid && $stable(w))
		else begin
			fail_count++;
			$error("w_valid dropped or w changed before w_ready");
		end

	ar_hold: assert property (@(posedge pll0_clock0) disable iff (!master_reset_n)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar))
		else begin
			fail_count++;
			$error("ar_valid dropped or ar changed before ar_ready");
		end

	// Completion only after a b or r handshake
	rsp_after_handshake: assert property (@(posedge pll0_clock0) disable iff (!master_reset_n)
		rsp_valid |-> $past((b_valid && b_ready) || (r_valid && r_ready)))
		else begin
			fail_count++;
			$error("rsp_valid without a preceding b or r handshake");
		end

	one_direction: assert property (@(posedge pll0_clock0) disable iff (!master_reset_n)
		!(aw_valid && ar_valid))
		else begin
			fail_count++;
			$error("aw_valid and ar_valid high together");
		end

endmodule

bind axi_single_master axi_handshake_sva u_sva (
	.pll0_clock0    (pll0_clock0),
	.master_reset_n (master_reset_n),
	.aw             (aw),
	.aw_valid       (aw_valid),
	.aw_ready       (aw_ready),
	.w              (w),
	.w_valid        (w_valid),
	.w_ready        (w_ready),
	.b_valid        (b_valid),
	.b_ready        (b_ready),
	.ar             (ar),
	.ar_valid       (ar_valid),
	.ar_ready       (ar_ready),
	.r_valid        (r_valid),
	.r_ready        (r_ready),
	.rsp_valid      (rsp_valid)
);

//--- tb_adc_uart_report.sv
`timescale 1ns/1ps

module tb_adc_uart_report;

	localparam hps_bus_pkg::addr_t uart_base    = hps_bus_pkg::uart_default_base;
	localparam int                 row_count    = 5;
	localparam int                 line_len     = 12;
	localparam int                 char_timeout = 3000;

	// One stimulus row: ADC sample and number of busy LSR reads per character
	typedef struct packed {
		adc_report_pkg::sample_t sample;
		logic [3:0]              busy;
	} row_t;

	logic                     pll0_clock0;
	logic                     master_reset_n;
	logic                     adc_convst;
	logic                     adc_sck;
	logic                     adc_sdi;
	logic                     adc_sdo;
	hps_bus_pkg::addr_chan_t  aw;
	logic                     aw_valid;
	logic                     aw_ready;
	hps_bus_pkg::wdata_chan_t w;
	logic                     w_valid;
	logic                     w_ready;
	hps_bus_pkg::resp_t       b_resp;
	logic                     b_valid;
	logic                     b_ready;
	hps_bus_pkg::addr_chan_t  ar;
	logic                     ar_valid;
	logic                     ar_ready;
	hps_bus_pkg::rdata_chan_t r;
	logic                     r_valid;
	logic                     r_ready;

	row_t                  table_rows [row_count];
	int                    checks;
	int                    errors;
	int unsigned           seed;
	int                    row_idx;

	// Bus slave model state
	int                    aw_stall;
	int                    w_stall;
	int                    b_stall;
	int                    ar_stall;
	int                    r_stall;
	bit                    got_aw;
	bit                    got_w;
	bit                    got_ar;
	adc_report_pkg::char_t wr_char;
	hps_bus_pkg::data_t    lsr_data;
	int                    lsr_reads;
	bit                    thre_seen;
	adc_report_pkg::char_t thr_q [$];
	int                    lsr_q [$];

	// ADC model state
	adc_report_pkg::sample_t     frame_word;
	int                          sdo_pos;
	bit                          sck_prev;
	int                          sdi_cnt;
	adc_report_pkg::adc_config_t sdi_bits;
	int                          cfg_frames;

	adc_uart_report #(
		.uart_base_addr      (uart_base),
		.report_delay_cycles (400),
		.conv_wait_cycles    (20),
		.sck_half_cycles     (2)
	) dut (
		.pll0_clock0    (pll0_clock0),
		.master_reset_n (master_reset_n),
		.adc_convst     (adc_convst),
		.adc_sck        (adc_sck),
		.adc_sdi        (adc_sdi),
		.adc_sdo        (adc_sdo),
		.aw             (aw),
		.aw_valid       (aw_valid),
		.aw_ready       (aw_ready),
		.w              (w),
		.w_valid        (w_valid),
		.w_ready        (w_ready),
		.b_resp         (b_resp),
		.b_valid        (b_valid),
		.b_ready        (b_ready),
		.ar             (ar),
		.ar_valid       (ar_valid),
		.ar_ready       (ar_ready),
		.r              (r),
		.r_valid        (r_valid),
		.r_ready        (r_ready)
	);

	initial begin
		pll0_clock0 = 1'b0;
		forever #10 pll0_clock0 = ~pll0_clock0;
	end

	// ========================================================================
	// Compare tasks and expected values
	// ========================================================================

	task automatic check_char(input string name, input adc_report_pkg::char_t exp,
			input adc_report_pkg::char_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s expected 8'h%02h actual 8'h%02h", name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input hps_bus_pkg::addr_t exp,
			input hps_bus_pkg::addr_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s expected 32'h%08h actual 32'h%08h", name, exp, act);
		end
	endtask

	task automatic check_strb(input string name, input hps_bus_pkg::strb_t exp,
			input hps_bus_pkg::strb_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s expected 4'b%04b actual 4'b%04b", name, exp, act);
		end
	endtask

	task automatic check_config(input string name, input adc_report_pkg::adc_config_t exp,
			input adc_report_pkg::adc_config_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s expected 6'b%06b actual 6'b%06b", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		if (act != exp) begin
			errors++;
			$display("[FAIL] %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s expected %b actual %b", name, exp, act);
		end
	endtask

	// Character idx of the report line for sample s
	function automatic adc_report_pkg::char_t expected_char(input adc_report_pkg::sample_t s,
			input int idx);
		string                 prefix;
		string                 digits;
		logic [15:0]           word;
		adc_report_pkg::char_t c;
		prefix = "ch0=0x";
		digits = "0123456789ABCDEF";
		word   = {4'h0, s};
		if (idx < 6) begin
			c = prefix[idx];
		end else if (idx < 10) begin
			c = digits[word[4 * (9 - idx) +: 4]];
		end else if (idx == 10) begin
			c = 8'h0D;
		end else begin
			c = 8'h0A;
		end
		return c;
	endfunction

	function automatic int current_row();
		return (row_idx < row_count) ? row_idx : row_count - 1;
	endfunction

	task automatic wait_for_char(output bit ok);
		int cycles;
		cycles = 0;
		while (thr_q.size() == 0 && cycles < char_timeout) begin
			@(negedge pll0_clock0);
			cycles++;
		end
		ok = (thr_q.size() != 0);
	endtask

	// ========================================================================
	// LTC2308 model and SDI config check
	// ========================================================================

	always @(negedge pll0_clock0) begin
		if (adc_convst) begin
			frame_word = table_rows[current_row()].sample;
			sdo_pos    = adc_report_pkg::adc_sample_bits - 1;
			sdi_cnt    = 0;
			adc_sdo   <= frame_word[sdo_pos];
		end else begin
			// Rising SCK since the last falling clock edge
			if (adc_sck && !sck_prev && sdi_cnt < 6) begin
				sdi_bits = {sdi_bits[4:0], adc_sdi};
				sdi_cnt++;
				if (sdi_cnt == 6) begin
					// Single-ended, channel 0, unipolar, no sleep
					check_config("adc sdi config", 6'b100010, sdi_bits);
					cfg_frames++;
				end
			end
			if (!adc_sck && sck_prev && sdo_pos > 0) begin
				sdo_pos--;
				adc_sdo <= frame_word[sdo_pos];
			end
		end
		sck_prev = adc_sck;
	end

	// ========================================================================
	// Bus slave with random ready stalls
	// ========================================================================

	always @(negedge pll0_clock0) begin
		if (master_reset_n) begin
			// Write response once address and data went through at earlier edges
			if (b_valid) begin
				b_valid <= 1'b0;
			end else if (got_aw && got_w) begin
				if (b_stall == 0) begin
					b_valid <= 1'b1;
					got_aw  = 1'b0;
					got_w   = 1'b0;
					b_stall = $urandom % 4;
					thr_q.push_back(wr_char);
					lsr_q.push_back(lsr_reads);
					if (!thre_seen) begin
						errors++;
						$display("THR written before the holding-empty bit was read as set");
					end
					lsr_reads = 0;
					thre_seen = 1'b0;
					if (wr_char == 8'h0A) begin
						row_idx++;
					end
				end else begin
					b_stall--;
				end
			end
			aw_ready <= 1'b0;
			if (aw_valid && !got_aw) begin
				if (aw_stall == 0) begin
					aw_ready <= 1'b1;
					got_aw   = 1'b1;
					aw_stall = $urandom % 4;
					check_addr("thr write address", uart_base, aw.addr);
				end else begin
					aw_stall--;
				end
			end
			w_ready <= 1'b0;
			if (w_valid && !got_w) begin
				if (w_stall == 0) begin
					w_ready <= 1'b1;
					got_w   = 1'b1;
					w_stall = $urandom % 4;
					wr_char = w.data[7:0];
					check_strb("thr write strobe", 4'b0001, w.strb);
				end else begin
					w_stall--;
				end
			end
			// LSR reads answer busy for the row's count, then holding-empty
			if (r_valid) begin
				r_valid <= 1'b0;
			end else if (got_ar) begin
				if (r_stall == 0) begin
					if (lsr_reads < table_rows[current_row()].busy) begin
						lsr_data = 32'h0000_0000;
					end else begin
						lsr_data  = 32'h0000_0060;
						thre_seen = 1'b1;
					end
					lsr_reads++;
					r_valid <= 1'b1;
					r.data  <= lsr_data;
					r.resp  <= 2'b00;
					got_ar  = 1'b0;
					r_stall = $urandom % 4;
				end else begin
					r_stall--;
				end
			end
			ar_ready <= 1'b0;
			if (ar_valid && !got_ar) begin
				if (ar_stall == 0) begin
					ar_ready <= 1'b1;
					got_ar   = 1'b1;
					ar_stall = $urandom % 4;
					// Line status register sits at offset 0x14
					check_addr("lsr read address", uart_base + 32'h0000_0014, ar.addr);
				end else begin
					ar_stall--;
				end
			end
		end
	end

	// ========================================================================
	// Stimulus table and line checks
	// ========================================================================

	initial begin
		int                    i;
		int                    k;
		bit                    ok;
		bit                    timed_out;
		adc_report_pkg::char_t got_char;
		int                    got_reads;
		seed = 32'h87c8;
		void'($urandom(seed));
		checks         = 0;
		errors         = 0;
		row_idx        = 0;
		cfg_frames     = 0;
		lsr_reads      = 0;
		thre_seen      = 1'b0;
		timed_out      = 1'b0;
		master_reset_n = 1'b0;
		adc_sdo        = 1'b0;
		aw_ready       = 1'b0;
		w_ready        = 1'b0;
		b_resp         = 2'b00;
		b_valid        = 1'b0;
		ar_ready       = 1'b0;
		r              = '0;
		r_valid        = 1'b0;
		// Columns: sample, busy LSR reads
		table_rows[0] = {12'h000, 4'd0};
		table_rows[1] = {12'hFFF, 4'd2};
		table_rows[2] = {12'hA5C, 4'd1};
		table_rows[3] = {12'h123, 4'd3};
		table_rows[4] = {12'h9E7, 4'd0};

		repeat (16) begin
			@(negedge pll0_clock0);
			check_level("reset adc_convst", 1'b0, adc_convst);
			check_level("reset adc_sck", 1'b0, adc_sck);
			check_level("reset aw_valid", 1'b0, aw_valid);
			check_level("reset w_valid", 1'b0, w_valid);
			check_level("reset ar_valid", 1'b0, ar_valid);
			check_level("reset b_ready", 1'b0, b_ready);
			check_level("reset r_ready", 1'b0, r_ready);
		end
		master_reset_n = 1'b1;

		for (i = 0; i < row_count && !timed_out; i++) begin
			for (k = 0; k < line_len && !timed_out; k++) begin
				wait_for_char(ok);
				if (!ok) begin
					errors++;
					timed_out = 1'b1;
					$display("Timed out waiting for character %0d of row %0d", k, i);
				end else begin
					got_char  = thr_q.pop_front();
					got_reads = lsr_q.pop_front();
					check_char($sformatf("row %0d char %0d", i, k),
						expected_char(table_rows[i].sample, k), got_char);
					check_count($sformatf("row %0d char %0d lsr reads", i, k),
						table_rows[i].busy + 1, got_reads);
				end
			end
		end

		if (cfg_frames == 0) begin
			errors++;
			$display("No ADC frame completed its config bits");
		end
		errors += dut.u_master.u_sva.fail_count;
		$display("Checks run %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- sim.f
hps_bus_pkg.sv
adc_report_pkg.sv
ltc2308_reader.sv
report_sequencer.sv
uart_tx_writer.sv
axi_single_master.sv
adc_uart_report.sv
adc_uart_report_sva.sv
tb_adc_uart_report.sv

//--- Bender.yml
package:
  name: adc_uart_report

sources:
  - hps_bus_pkg.sv
  - adc_report_pkg.sv
  - ltc2308_reader.sv
  - report_sequencer.sv
  - uart_tx_writer.sv
  - axi_single_master.sv
  - adc_uart_report.sv
  - target: test
    files:
      - adc_uart_report_sva.sv
      - tb_adc_uart_report.sv
